// File: hw/mem_test_pkg.sv
`default_nettype none

package mem_test_pkg;

    localparam int DATA_WIDTH      = 64;
    localparam int LANE_WIDTH      = 32;
    localparam int LANES           = DATA_WIDTH / LANE_WIDTH;  // Lane 0 sits in the low bits
    localparam int ADDR_WIDTH      = 32;
    localparam int LEN_WIDTH       = 4;
    localparam int ERR_COUNT_WIDTH = 16;

    localparam int MEM_WORDS     = 256;
    localparam int MEM_IDX_WIDTH = $clog2(MEM_WORDS);
    localparam int BEAT_BYTES    = DATA_WIDTH / 8;
    localparam int STRB_WIDTH    = BEAT_BYTES;
    localparam int IDX_LSB       = $clog2(BEAT_BYTES);
    localparam int WRAP_BITS     = IDX_LSB + MEM_IDX_WIDTH;  // Memory aliases every 2 KiB

    localparam logic [2:0] AXI_SIZE       = 3'd3;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [7:0] AXI_ID         = 8'h10;

    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;  // x^32+x^22+x^2+x+1 in Galois form

    localparam logic [7:0] REG_CTRL      = 8'h00;
    localparam logic [7:0] REG_ADDR      = 8'h04;
    localparam logic [7:0] REG_LEN       = 8'h08;
    localparam logic [7:0] REG_SEED      = 8'h0C;
    localparam logic [7:0] REG_STATUS    = 8'h10;
    localparam logic [7:0] REG_ERR_COUNT = 8'h14;
    localparam logic [7:0] REG_ERR_ADDR  = 8'h18;

    localparam int CTRL_START = 0;
    localparam int CTRL_WRITE = 1;
    localparam int CTRL_READ  = 2;
    localparam int STAT_BUSY  = 0;
    localparam int STAT_DONE  = 1;
    localparam int STAT_FAIL  = 2;

    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_WAIT_RDY = 3'd1;
    localparam logic [2:0] ST_WRITE    = 3'd2;
    localparam logic [2:0] ST_RESP     = 3'd3;
    localparam logic [2:0] ST_READ     = 3'd4;
    localparam logic [2:0] ST_FINISH   = 3'd5;

endpackage

`default_nettype wire

// File: hw/pattern_gen.sv
`timescale 1ns/10ps
`default_nettype none

module pattern_gen import mem_test_pkg::*; (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   load,
    input  wire [31:0]            seed,
    input  wire                   advance,
    output logic [DATA_WIDTH-1:0] word
);

    logic [31:0] state;
    logic [31:0] last_lane;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? LFSR_POLY : 32'h0);
    endfunction

    // Each lane is one more shift than the lane below it
    always_comb begin
        logic [31:0] s;
        s = state;
        for (int i = 0; i < LANES; i++) begin
            s = lfsr_step(s);
            word[i*LANE_WIDTH +: LANE_WIDTH] = s;
        end
        last_lane = s;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= 32'h1;
        end else if (load) begin
            state <= (seed == 32'h0) ? 32'h1 : seed;  // All-zero state would lock up
        end else if (advance) begin
            state <= last_lane;  // Next beat carries on the same sequence
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_test_regs.sv
`timescale 1ns/10ps
`default_nettype none

module mem_test_regs import mem_test_pkg::*; (
    input  wire                        clk,
    input  wire                        rstn,

    input  wire [7:0]                  paddr,
    input  wire                        psel,
    input  wire                        penable,
    input  wire                        pwrite,
    input  wire [31:0]                 pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,

    input  wire                        busy,
    input  wire                        done,
    input  wire                        fail,
    input  wire [ERR_COUNT_WIDTH-1:0]  err_count,
    input  wire [ADDR_WIDTH-1:0]       err_addr,

    output logic                       start,
    output logic [ADDR_WIDTH-1:0]      cfg_addr,
    output logic [LEN_WIDTH-1:0]       cfg_len,
    output logic [31:0]                cfg_seed,
    output logic                       cfg_write,
    output logic                       cfg_read
);

    logic access;
    logic mapped;
    logic read_only;
    logic blocked;
    logic wr_ok;

    assign pready  = 1'b1;  // No wait states
    assign access  = psel & penable;
    assign blocked = busy | start;  // A start already issued counts as running
    assign pslverr = access & (~mapped | (pwrite & (read_only | blocked)));
    assign wr_ok   = access & pwrite & ~pslverr;

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        prdata    = 32'h0;
        case (paddr)
            REG_CTRL: begin
                prdata[CTRL_WRITE] = cfg_write;
                prdata[CTRL_READ]  = cfg_read;
            end
            REG_ADDR:   prdata = cfg_addr;
            REG_LEN:    prdata[LEN_WIDTH-1:0] = cfg_len;
            REG_SEED:   prdata = cfg_seed;
            REG_STATUS: begin
                read_only         = 1'b1;
                prdata[STAT_BUSY] = busy;
                prdata[STAT_DONE] = done;
                prdata[STAT_FAIL] = fail;
            end
            REG_ERR_COUNT: begin
                read_only                   = 1'b1;
                prdata[ERR_COUNT_WIDTH-1:0] = err_count;
            end
            REG_ERR_ADDR: begin
                read_only = 1'b1;
                prdata    = err_addr;
            end
            default: mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cfg_addr  <= '0;
            cfg_len   <= '0;
            cfg_seed  <= '0;
            cfg_write <= 1'b0;
            cfg_read  <= 1'b0;
            start     <= 1'b0;
        end else begin
            start <= wr_ok && paddr == REG_CTRL && pwdata[CTRL_START];  // One cycle only
            if (wr_ok) begin
                case (paddr)
                    REG_CTRL: begin
                        cfg_write <= pwdata[CTRL_WRITE];
                        cfg_read  <= pwdata[CTRL_READ];
                    end
                    REG_ADDR: cfg_addr <= pwdata;
                    REG_LEN:  cfg_len  <= pwdata[LEN_WIDTH-1:0];
                    REG_SEED: cfg_seed <= pwdata;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/axi_test_master.sv
`timescale 1ns/10ps
`default_nettype none

module axi_test_master import mem_test_pkg::*; (
    input  wire                        clk,
    input  wire                        rstn,

    input  wire                        start,
    input  wire [ADDR_WIDTH-1:0]       cfg_addr,
    input  wire [LEN_WIDTH-1:0]        cfg_len,
    input  wire [31:0]                 cfg_seed,
    input  wire                        cfg_write,
    input  wire                        cfg_read,
    output logic                       busy,
    output logic                       done,
    output logic                       fail,
    output logic [ERR_COUNT_WIDTH-1:0] err_count,
    output logic [ADDR_WIDTH-1:0]      err_addr,

    input  wire                        mem_ready,

    output logic [ADDR_WIDTH-1:0]      awaddr,
    output logic [7:0]                 awid,
    output logic [LEN_WIDTH-1:0]       awlen,
    output logic [2:0]                 awsize,
    output logic [1:0]                 awburst,
    output logic                       awvalid,
    input  wire                        awready,

    output logic [DATA_WIDTH-1:0]      wdata,
    output logic [STRB_WIDTH-1:0]      wstrb,
    output logic                       wlast,
    output logic                       wvalid,
    input  wire                        wready,

    input  wire                        bvalid,
    output logic                       bready,

    output logic [ADDR_WIDTH-1:0]      araddr,
    output logic [7:0]                 arid,
    output logic [LEN_WIDTH-1:0]       arlen,
    output logic [2:0]                 arsize,
    output logic [1:0]                 arburst,
    output logic                       arvalid,
    input  wire                        arready,

    input  wire [DATA_WIDTH-1:0]       rdata,
    input  wire                        rlast,
    input  wire                        rvalid,
    output logic                       rready
);

    logic [2:0]            state;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [LEN_WIDTH-1:0]  len_q;
    logic                  write_q;
    logic                  read_q;
    logic [LEN_WIDTH-1:0]  beat;
    logic                  err_seen;
    logic                  start_ok;
    logic                  w_fire;
    logic                  r_fire;
    logic [DATA_WIDTH-1:0] expected;
    logic [WRAP_BITS-1:0]  beat_off;

    assign start_ok = start & ~busy;
    assign w_fire   = wvalid & wready;
    assign r_fire   = rvalid & rready & (state == ST_READ);
    assign beat_off = addr_q[WRAP_BITS-1:0] + WRAP_BITS'(beat * BEAT_BYTES);

    assign awaddr  = addr_q;
    assign awid    = AXI_ID;
    assign awlen   = len_q;
    assign awsize  = AXI_SIZE;
    assign awburst = AXI_BURST_INCR;
    assign wstrb   = '1;
    assign wlast   = (beat == len_q);
    assign bready  = 1'b1;
    assign araddr  = addr_q;
    assign arid    = AXI_ID;
    assign arlen   = len_q;
    assign arsize  = AXI_SIZE;
    assign arburst = AXI_BURST_INCR;
    assign rready  = 1'b1;

    pattern_gen wr_pat (
        .clk     (clk),
        .rstn    (rstn),
        .load    (start_ok),
        .seed    (cfg_seed),
        .advance (w_fire),
        .word    (wdata)
    );

    pattern_gen rd_pat (
        .clk     (clk),
        .rstn    (rstn),
        .load    (start_ok),
        .seed    (cfg_seed),
        .advance (r_fire),
        .word    (expected)
    );

    always_ff @(posedge clk) begin
        if (start_ok) begin
            addr_q <= cfg_addr;
            len_q  <= cfg_len;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= ST_IDLE;
            busy      <= 1'b0;
            done      <= 1'b0;
            fail      <= 1'b0;
            err_count <= '0;
            err_addr  <= '0;
            err_seen  <= 1'b0;
            write_q   <= 1'b0;
            read_q    <= 1'b0;
            beat      <= '0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            arvalid   <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                awvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                arvalid <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (start_ok) begin
                        busy      <= 1'b1;
                        done      <= 1'b0;
                        fail      <= 1'b0;
                        err_count <= '0;
                        err_addr  <= '0;
                        err_seen  <= 1'b0;
                        write_q   <= cfg_write;
                        read_q    <= cfg_read;
                        state     <= ST_WAIT_RDY;
                    end
                end
                ST_WAIT_RDY: begin
                    beat <= '0;
                    if (mem_ready) begin
                        if (write_q) begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            state   <= ST_WRITE;
                        end else if (read_q) begin
                            arvalid <= 1'b1;
                            state   <= ST_READ;
                        end else begin
                            state <= ST_FINISH;
                        end
                    end
                end
                ST_WRITE: begin
                    if (w_fire) begin
                        beat <= beat + 1'b1;
                        if (wlast) begin
                            wvalid <= 1'b0;
                            state  <= ST_RESP;
                        end
                    end
                end
                ST_RESP: begin
                    beat <= '0;
                    if (bvalid) begin
                        if (read_q) begin
                            arvalid <= 1'b1;
                            state   <= ST_READ;
                        end else begin
                            state <= ST_FINISH;
                        end
                    end
                end
                ST_READ: begin
                    if (r_fire) begin
                        beat <= beat + 1'b1;
                        if (rdata != expected) begin
                            if (err_count != '1) begin
                                err_count <= err_count + 1'b1;  // Saturates at all ones
                            end
                            if (!err_seen) begin
                                err_seen <= 1'b1;
                                err_addr <= {addr_q[ADDR_WIDTH-1:WRAP_BITS], beat_off};
                            end
                        end
                        if (rlast) begin
                            state <= ST_FINISH;
                        end
                    end
                end
                ST_FINISH: begin
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    fail  <= (err_count != '0);
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/axi_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_model import mem_test_pkg::*; (
    input  wire                   clk,
    input  wire                   rstn,

    input  wire [ADDR_WIDTH-1:0]  awaddr,
    input  wire [LEN_WIDTH-1:0]   awlen,
    input  wire [2:0]             awsize,
    input  wire [1:0]             awburst,
    input  wire                   awvalid,
    output logic                  awready,

    input  wire [DATA_WIDTH-1:0]  wdata,
    input  wire [STRB_WIDTH-1:0]  wstrb,
    input  wire                   wlast,
    input  wire                   wvalid,
    output logic                  wready,

    output logic                  bvalid,
    input  wire                   bready,

    input  wire [ADDR_WIDTH-1:0]  araddr,
    input  wire [LEN_WIDTH-1:0]   arlen,
    input  wire [2:0]             arsize,
    input  wire [1:0]             arburst,
    input  wire                   arvalid,
    output logic                  arready,

    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  rlast,
    output logic                  rvalid,
    input  wire                   rready,

    output logic                  mem_ready
);

    logic [DATA_WIDTH-1:0]    mem [MEM_WORDS];
    logic [MEM_IDX_WIDTH-1:0] clr_idx;
    logic                     clearing;
    logic                     wr_active;
    logic                     wr_ok;
    logic [MEM_IDX_WIDTH-1:0] wr_idx;
    logic [LEN_WIDTH-1:0]     wr_left;
    logic                     rd_ok;
    logic [MEM_IDX_WIDTH-1:0] rd_idx;
    logic [LEN_WIDTH-1:0]     rd_left;
    logic                     w_fire;

    assign awready = mem_ready & ~wr_active & ~bvalid;
    assign wready  = wr_active;
    assign arready = mem_ready & ~rvalid;
    assign w_fire  = wvalid & wready;
    assign rlast   = (rd_left == '0);
    assign rdata   = rd_ok ? mem[rd_idx] : '0;  // Unsupported bursts read as zero

    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clr_idx] <= '0;
        end else if (w_fire && wr_ok && &wstrb) begin
            mem[wr_idx] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            clr_idx   <= '0;
            clearing  <= 1'b1;
            mem_ready <= 1'b0;
            wr_active <= 1'b0;
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
        end else begin
            if (clearing) begin
                clr_idx <= clr_idx + 1'b1;
                if (clr_idx == MEM_IDX_WIDTH'(MEM_WORDS - 1)) begin
                    clearing  <= 1'b0;
                    mem_ready <= 1'b1;
                end
            end
            if (awvalid && awready) begin
                wr_active <= 1'b1;
            end else if (w_fire && (wlast || wr_left == '0)) begin
                wr_active <= 1'b0;
                bvalid    <= 1'b1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready && rlast) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Burst address and length tracking
    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            wr_idx  <= awaddr[IDX_LSB +: MEM_IDX_WIDTH];
            wr_left <= awlen;
            wr_ok   <= awsize == AXI_SIZE && awburst == AXI_BURST_INCR;
        end else if (w_fire) begin
            wr_idx  <= wr_idx + 1'b1;  // Wraps at the top of memory
            wr_left <= wr_left - 1'b1;
        end
        if (arvalid && arready) begin
            rd_idx  <= araddr[IDX_LSB +: MEM_IDX_WIDTH];
            rd_left <= arlen;
            rd_ok   <= arsize == AXI_SIZE && arburst == AXI_BURST_INCR;
        end else if (rvalid && rready) begin
            rd_idx  <= rd_idx + 1'b1;
            rd_left <= rd_left - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_test_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_test_top import mem_test_pkg::*; (
    input  wire         clk,
    input  wire         rstn,
    input  wire [7:0]   paddr,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire [31:0]  pwdata,
    output wire [31:0]  prdata,
    output wire         pready,
    output wire         pslverr,
    output wire         test_done,
    output wire         test_fail
);

    wire                       start;
    wire [ADDR_WIDTH-1:0]      cfg_addr;
    wire [LEN_WIDTH-1:0]       cfg_len;
    wire [31:0]                cfg_seed;
    wire                       cfg_write;
    wire                       cfg_read;
    wire                       busy;
    wire [ERR_COUNT_WIDTH-1:0] err_count;
    wire [ADDR_WIDTH-1:0]      err_addr;
    wire                       mem_ready;

    wire [ADDR_WIDTH-1:0]      awaddr;
    wire [LEN_WIDTH-1:0]       awlen;
    wire [2:0]                 awsize;
    wire [1:0]                 awburst;
    wire                       awvalid;
    wire                       awready;
    wire [DATA_WIDTH-1:0]      wdata;
    wire [STRB_WIDTH-1:0]      wstrb;
    wire                       wlast;
    wire                       wvalid;
    wire                       wready;
    wire                       bvalid;
    wire                       bready;
    wire [ADDR_WIDTH-1:0]      araddr;
    wire [LEN_WIDTH-1:0]       arlen;
    wire [2:0]                 arsize;
    wire [1:0]                 arburst;
    wire                       arvalid;
    wire                       arready;
    wire [DATA_WIDTH-1:0]      rdata;
    wire                       rlast;
    wire                       rvalid;
    wire                       rready;

    mem_test_regs u_regs (
        .clk       (clk),
        .rstn      (rstn),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .busy      (busy),
        .done      (test_done),
        .fail      (test_fail),
        .err_count (err_count),
        .err_addr  (err_addr),
        .start     (start),
        .cfg_addr  (cfg_addr),
        .cfg_len   (cfg_len),
        .cfg_seed  (cfg_seed),
        .cfg_write (cfg_write),
        .cfg_read  (cfg_read)
    );

    axi_test_master u_master (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .cfg_addr  (cfg_addr),
        .cfg_len   (cfg_len),
        .cfg_seed  (cfg_seed),
        .cfg_write (cfg_write),
        .cfg_read  (cfg_read),
        .busy      (busy),
        .done      (test_done),
        .fail      (test_fail),
        .err_count (err_count),
        .err_addr  (err_addr),
        .mem_ready (mem_ready),
        .awaddr    (awaddr),
        .awid      (),  // The memory model has no ID handling
        .awlen     (awlen),
        .awsize    (awsize),
        .awburst   (awburst),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arid      (),
        .arlen     (arlen),
        .arsize    (arsize),
        .arburst   (arburst),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    axi_mem_model u_mem (
        .clk       (clk),
        .rstn      (rstn),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .awburst   (awburst),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arlen     (arlen),
        .arsize    (arsize),
        .arburst   (arburst),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready),
        .mem_ready (mem_ready)
    );

endmodule

`default_nettype wire

// File: bench/mem_test_tests.svh
`ifndef MEM_TEST_TESTS_SVH
`define MEM_TEST_TESTS_SVH

logic [63:0] exp_beats [16];
logic [63:0] stored_beats [16];

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ LFSR_POLY;
    end
    return s >> 1;
endfunction

// Address of beat i, wrapping inside the 2 KiB window of the base
function automatic logic [31:0] beat_addr(input logic [31:0] base, input int i);
    logic [10:0] off;
    off = base[10:0] + 11'(i * BEAT_BYTES);
    return {base[31:11], off};
endfunction

function automatic logic [31:0] random_addr();
    return $urandom() & 32'hFFFF_FFF8;
endfunction

// Lane 0 is one shift on, lane 1 two shifts on, and the next beat starts from lane 1
task automatic model(input logic [31:0] seed);
    logic [31:0] s;
    logic [31:0] lo;
    s = (seed == 32'h0) ? 32'h1 : seed;
    for (int i = 0; i < 16; i++) begin
        s  = lfsr_next(s);
        lo = s;
        s  = lfsr_next(s);
        exp_beats[i] = {s, lo};
    end
endtask

// Memory holds the stored seed's pattern, or zeros when have_data is clear
task automatic predict(input logic have_data, input logic [31:0] stored_seed,
                       input logic [31:0] read_seed, input logic [31:0] base,
                       output logic [31:0] count, output logic [31:0] first);
    model(stored_seed);
    for (int i = 0; i < 16; i++) begin
        stored_beats[i] = have_data ? exp_beats[i] : 64'h0;
    end
    model(read_seed);
    count = 32'h0;
    first = 32'h0;
    for (int i = 0; i < 16; i++) begin
        if (stored_beats[i] != exp_beats[i]) begin
            if (count == 32'h0) begin
                first = beat_addr(base, i);
            end
            count++;
        end
    end
endtask

task automatic check_status(input logic exp_fail, input logic [31:0] exp_count,
                            input logic [31:0] exp_addr);
    logic [31:0] rd;
    logic        err;
    apb_read(REG_STATUS, rd, err);
    check_flag("STATUS done", 1'b1, rd[STAT_DONE]);
    check_flag("STATUS busy", 1'b0, rd[STAT_BUSY]);
    check_flag("STATUS fail", exp_fail, rd[STAT_FAIL]);
    apb_read(REG_ERR_COUNT, rd, err);
    check_word("ERR_COUNT", exp_count, rd);
    apb_read(REG_ERR_ADDR, rd, err);
    check_word("ERR_ADDR", exp_addr, rd);
    check_flag("test_done pin", 1'b1, test_done);
    check_flag("test_fail pin", exp_fail, test_fail);
endtask

task automatic test_registers;
    logic [7:0]  offs [7];
    logic [31:0] rd;
    logic        err;
    offs = '{REG_CTRL, REG_ADDR, REG_LEN, REG_SEED, REG_STATUS, REG_ERR_COUNT, REG_ERR_ADDR};
    open_test("registers");
    foreach (offs[i]) begin
        apb_read(offs[i], rd, err);
        check_word($sformatf("reset value at %h", offs[i]), 32'h0, rd);
        check_flag("read pslverr", 1'b0, err);
    end
    apb_write(REG_ADDR, 32'h1234_5678, err);
    apb_read(REG_ADDR, rd, err);
    check_word("ADDR readback", 32'h1234_5678, rd);
    apb_write(REG_LEN, 32'hFFFF_FFF5, err);
    apb_read(REG_LEN, rd, err);
    check_word("LEN readback", 32'h0000_0005, rd);  // Only four bits are kept
    apb_write(REG_SEED, 32'h9E37_79B9, err);
    apb_read(REG_SEED, rd, err);
    check_word("SEED readback", 32'h9E37_79B9, rd);
    apb_read(8'h1C, rd, err);
    check_flag("unmapped read pslverr", 1'b1, err);
    apb_write(REG_STATUS, 32'h7, err);
    check_flag("STATUS write pslverr", 1'b1, err);
    close_test();
endtask

task automatic test_unwritten;
    logic [31:0] addr;
    logic [31:0] seed;
    logic [31:0] count;
    logic [31:0] first;
    open_test("unwritten memory");
    addr = random_addr();
    seed = $urandom();
    predict(1'b0, 32'h0, seed, addr, count, first);
    run_test(addr, 4'd15, seed, 1'b0, 1'b1);
    check_status(count != 0, count, first);
    close_test();
endtask

task automatic test_pass(input string name, input logic [31:0] addr, input logic [3:0] len);
    open_test(name);
    run_test(addr, len, $urandom(), 1'b1, 1'b1);
    check_status(1'b0, 32'h0, 32'h0);
    close_test();
endtask

task automatic test_mismatch;
    logic [31:0] addr;
    logic [31:0] seed_a;
    logic [31:0] seed_b;
    logic [31:0] count;
    logic [31:0] first;
    open_test("read-only mismatch");
    addr   = random_addr();
    seed_a = $urandom();
    seed_b = seed_a ^ 32'h0000_0100;
    run_test(addr, 4'd15, seed_a, 1'b1, 1'b0);
    check_status(1'b0, 32'h0, 32'h0);
    predict(1'b1, seed_a, seed_b, addr, count, first);
    run_test(addr, 4'd15, seed_b, 1'b0, 1'b1);
    check_status(count != 0, count, first);
    close_test();
endtask

task automatic test_busy;
    logic [31:0] seed;
    logic [31:0] rd;
    logic        err;
    open_test("busy protection");
    seed = $urandom();
    start_test(random_addr(), 4'd15, seed, 1'b1, 1'b1);
    apb_write(REG_SEED, ~seed, err);
    check_flag("SEED write while busy pslverr", 1'b1, err);
    apb_write(REG_CTRL, 32'h7, err);
    check_flag("second start pslverr", 1'b1, err);
    wait_done();
    check_status(1'b0, 32'h0, 32'h0);
    apb_read(REG_SEED, rd, err);
    check_word("SEED kept", seed, rd);
    close_test();
endtask

task automatic test_restart;
    logic [31:0] addr;
    logic [31:0] seed;
    logic [31:0] count;
    logic [31:0] first;
    logic [31:0] rd;
    logic        err;
    open_test("restart");
    addr = random_addr();
    seed = $urandom();
    run_test(addr, 4'd15, seed, 1'b1, 1'b0);
    predict(1'b1, seed, ~seed, addr, count, first);
    run_test(addr, 4'd15, ~seed, 1'b0, 1'b1);
    check_status(1'b1, count, first);
    start_test(addr, 4'd15, seed, 1'b1, 1'b1);
    apb_read(REG_STATUS, rd, err);
    check_flag("fail after restart", 1'b0, rd[STAT_FAIL]);
    apb_read(REG_ERR_COUNT, rd, err);
    check_word("ERR_COUNT after restart", 32'h0, rd);
    apb_read(REG_ERR_ADDR, rd, err);
    check_word("ERR_ADDR after restart", 32'h0, rd);
    wait_done();
    check_status(1'b0, 32'h0, 32'h0);
    close_test();
endtask

`endif

// File: bench/mem_test_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_test_tb import mem_test_pkg::*;;

    localparam int TIMEOUT_CYCLES = ((3 + MEM_WORDS + 16 * (2 * 16 + 40)) / 100 + 1) * 100;

    logic        clk;
    logic        rstn;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        test_done;
    logic        test_fail;

    int          cycles;
    int          pass_count;
    int          fail_count;
    int          test_errs;
    string       cur_name;

    mem_test_top dut (
        .clk       (clk),
        .rstn      (rstn),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .test_done (test_done),
        .test_fail (test_fail)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        @(negedge clk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #2;
        err = pslverr;  // Sampled well before the edge that ends the access
        check_flag("write pready", 1'b1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #2;
        data = prdata;
        err  = pslverr;
        check_flag("read pready", 1'b1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: %s expected %h actual %h", cur_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: %s expected %b actual %b", cur_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic open_test(input string name);
        cur_name  = name;
        test_errs = 0;
    endtask

    task automatic close_test;
        if (test_errs == 0) begin
            pass_count++;
            $display("PASS %s", cur_name);
        end else begin
            fail_count++;
            $display("FAIL %s with %0d mismatches", cur_name, test_errs);
        end
    endtask

    task automatic start_test(input logic [31:0] addr, input logic [3:0] len,
                              input logic [31:0] seed, input logic do_write,
                              input logic do_read);
        logic [31:0] ctrl;
        logic        err;
        ctrl = 32'h0;
        ctrl[CTRL_START] = 1'b1;
        ctrl[CTRL_WRITE] = do_write;
        ctrl[CTRL_READ]  = do_read;
        apb_write(REG_ADDR, addr, err);
        check_flag("ADDR write pslverr", 1'b0, err);
        apb_write(REG_LEN, {28'h0, len}, err);
        check_flag("LEN write pslverr", 1'b0, err);
        apb_write(REG_SEED, seed, err);
        check_flag("SEED write pslverr", 1'b0, err);
        apb_write(REG_CTRL, ctrl, err);
        check_flag("CTRL write pslverr", 1'b0, err);
    endtask

    // Polls until the engine reports done with busy clear
    task automatic wait_done;
        logic [31:0] st;
        logic        err;
        st = 32'h0;
        while (!st[STAT_DONE] || st[STAT_BUSY]) begin
            apb_read(REG_STATUS, st, err);
        end
    endtask

    task automatic run_test(input logic [31:0] addr, input logic [3:0] len,
                            input logic [31:0] seed, input logic do_write,
                            input logic do_read);
        start_test(addr, len, seed, do_write, do_read);
        wait_done();
    endtask

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        paddr      = 8'h0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = 32'h0;
        cycles     = 0;
        pass_count = 0;
        fail_count = 0;
        test_errs  = 0;
        void'($urandom(32'h28a2_f2f0));
        repeat (3) @(negedge clk);
        rstn = 1'b1;

        test_registers();
        test_unwritten();
        test_pass("pass len 0", random_addr(), 4'd0);
        test_pass("pass len 1", random_addr(), 4'd1);
        test_pass("pass len 15", random_addr(), 4'd15);
        test_pass("pass across wrap", 32'h1000_07C8, 4'd15);
        test_mismatch();
        test_busy();
        test_restart();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    `include "mem_test_tests.svh"

endmodule

`default_nettype wire

// File: tb.f
+incdir+bench
hw/mem_test_pkg.sv
hw/pattern_gen.sv
hw/mem_test_regs.sv
hw/axi_test_master.sv
hw/axi_mem_model.sv
hw/mem_test_top.sv
bench/mem_test_tb.sv
